/* src/mem_pkg.sv */
package mem_pkg;

    // data path and RAM geometry
    localparam int xlen      = 64;
    localparam int ram_bytes = 4096;
    localparam int ram_words = ram_bytes / 8;       // one entry per doubleword
    localparam int ram_aw    = $clog2(ram_words);   // index taken from addr[11:3]

    // RISC-V func3 size and sign codes, low two bits give the size
    localparam logic [2:0] func3_lb  = 3'd0;
    localparam logic [2:0] func3_lh  = 3'd1;
    localparam logic [2:0] func3_lw  = 3'd2;
    localparam logic [2:0] func3_ld  = 3'd3;
    localparam logic [2:0] func3_lbu = 3'd4;
    localparam logic [2:0] func3_lhu = 3'd5;
    localparam logic [2:0] func3_lwu = 3'd6;

    // register write source
    localparam logic [1:0] wsel_alu  = 2'd0;
    localparam logic [1:0] wsel_load = 2'd1;
    localparam logic [1:0] wsel_pc4  = 2'd2;

    // execute to memory record, 205 bits
    typedef struct packed {
        logic [xlen-1:0] store_data;
        logic            mem_wen;
        logic            mem_ren;
        logic [2:0]      func3;
        logic [1:0]      wreg_sel;
        logic            reg_wen;
        logic [4:0]      rd;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] alu_result;
    } ex_mem_bus_t;

    // memory to writeback record, 200 bits
    typedef struct packed {
        logic            reg_wen;
        logic [4:0]      rd;
        logic [1:0]      wreg_sel;
        logic [xlen-1:0] load_data;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] pc;
    } mem_wb_bus_t;

    // byte offset rounded down to the access size
    function automatic logic [2:0] align_offset(input logic [2:0] addr, input logic [1:0] size);
        logic [2:0] mask;
        mask = 3'b111 << size;
        return addr & mask;
    endfunction

endpackage

/* src/pipe_stage.sv */
`timescale 1ns/100ps

module pipe_stage
    import mem_pkg::*;
#(
    parameter type payload_t = ex_mem_bus_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     out_allowin,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_payload
);

    logic     valid_q;
    logic     ready_go;
    payload_t payload_q;

    assign ready_go = 1'b1; // single cycle stage, never holds an item

    // accept when empty or when the held item leaves this edge
    assign in_allowin  = !valid_q || (ready_go && out_allowin);
    assign out_valid   = valid_q && ready_go;
    assign out_payload = payload_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid; // bubble in if nothing offered
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            payload_q <= in_payload; // load on transfer only
        end
    end

endmodule

/* src/store_format.sv */
`timescale 1ns/100ps

module store_format
    import mem_pkg::*;
(
    input  logic [2:0]      addr,
    input  logic [2:0]      func3,
    input  logic [xlen-1:0] wdata,
    output logic [7:0]      byte_en,
    output logic [xlen-1:0] lane_data
);

    logic [1:0] size;
    logic [2:0] offset;
    logic [7:0] base_en;

    assign size   = func3[1:0]; // sign bit is meaningless for stores
    assign offset = align_offset(addr, size);

    always_comb begin
        case (size)
            func3_lb[1:0]: begin
                base_en   = 8'h01;
                lane_data = {8{wdata[7:0]}};
            end
            func3_lh[1:0]: begin
                base_en   = 8'h03;
                lane_data = {4{wdata[15:0]}};
            end
            func3_lw[1:0]: begin
                base_en   = 8'h0f;
                lane_data = {2{wdata[31:0]}};
            end
            default: begin // doubleword
                base_en   = 8'hff;
                lane_data = wdata;
            end
        endcase
    end

    // replicated data already sits in every lane, only the enables move
    assign byte_en = base_en << offset;

endmodule

/* src/data_ram.sv */
`timescale 1ns/100ps

module data_ram
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            we,
    input  logic [7:0]      byte_en,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata
);

    logic [xlen-1:0]   mem [ram_words];
    logic [ram_aw-1:0] index;

    // upper address bits ignored, so accesses wrap at 4 KiB
    assign index = addr[ram_aw+2:3];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en[i]) begin
                    mem[index][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[index]; // asynchronous read port

endmodule

/* src/load_extend.sv */
`timescale 1ns/100ps

module load_extend
    import mem_pkg::*;
(
    input  logic [2:0]      addr,
    input  logic [2:0]      func3,
    input  logic [xlen-1:0] word,
    output logic [xlen-1:0] value
);

    logic [2:0]      offset;
    logic [xlen-1:0] shifted;

    assign offset  = align_offset(addr, func3[1:0]);
    assign shifted = word >> {offset, 3'b000}; // field down to bit 0

    always_comb begin
        case (func3)
            func3_lb: begin
                value = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            end
            func3_lh: begin
                value = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            end
            func3_lw: begin
                value = {{(xlen-32){shifted[31]}}, shifted[31:0]};
            end
            func3_ld: begin
                value = word; // offset is always zero here
            end
            func3_lbu: begin
                value = {{(xlen-8){1'b0}}, shifted[7:0]};
            end
            func3_lhu: begin
                value = {{(xlen-16){1'b0}}, shifted[15:0]};
            end
            func3_lwu: begin
                value = {{(xlen-32){1'b0}}, shifted[31:0]};
            end
            default: begin
                value = '0; // code 7 is not a load
            end
        endcase
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            es_valid,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] store_data,
    input  logic            mem_wen,
    input  logic            mem_ren,
    input  logic [2:0]      func3,
    input  logic [1:0]      wreg_sel,
    input  logic            reg_wen,
    input  logic [4:0]      rd,
    input  logic            ws_allowin,
    output logic            ms_allowin,
    output logic            ms_to_ws_valid,
    output mem_wb_bus_t     ms_to_ws_bus
);

    ex_mem_bus_t     es_bus;
    ex_mem_bus_t     ms_bus;
    logic            ram_we;
    logic [7:0]      byte_en;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] ram_rdata;
    logic [xlen-1:0] load_value;

    assign es_bus = '{
        store_data: store_data,
        mem_wen:    mem_wen,
        mem_ren:    mem_ren,
        func3:      func3,
        wreg_sel:   wreg_sel,
        reg_wen:    reg_wen,
        rd:         rd,
        pc:         pc,
        alu_result: alu_result
    };

    pipe_stage #(
        .payload_t (ex_mem_bus_t)
    ) u_ms_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (es_valid),
        .in_payload  (es_bus),
        .out_allowin (ws_allowin),
        .in_allowin  (ms_allowin),
        .out_valid   (ms_to_ws_valid),
        .out_payload (ms_bus)
    );

    // write only on the edge the item leaves, so each store hits once
    assign ram_we = ms_to_ws_valid && ms_bus.mem_wen && ws_allowin;

    store_format u_store_format (
        .addr      (ms_bus.alu_result[2:0]),
        .func3     (ms_bus.func3),
        .wdata     (ms_bus.store_data),
        .byte_en   (byte_en),
        .lane_data (lane_data)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .we      (ram_we),
        .byte_en (byte_en),
        .addr    (ms_bus.alu_result),
        .wdata   (lane_data),
        .rdata   (ram_rdata)
    );

    load_extend u_load_extend (
        .addr  (ms_bus.alu_result[2:0]),
        .func3 (ms_bus.func3),
        .word  (ram_rdata),
        .value (load_value)
    );

    assign ms_to_ws_bus = '{
        reg_wen:    ms_bus.reg_wen,
        rd:         ms_bus.rd,
        wreg_sel:   ms_bus.wreg_sel,
        load_data:  ms_bus.mem_ren ? load_value : '0,
        alu_result: ms_bus.alu_result,
        pc:         ms_bus.pc
    };

endmodule

/* src/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            ms_to_ws_valid,
    input  mem_wb_bus_t     ms_to_ws_bus,
    output logic            ws_allowin,
    output logic            rf_wen,
    output logic [4:0]      rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic [xlen-1:0] wb_pc
);

    mem_wb_bus_t ws_bus;
    logic        ws_valid;

    // nothing past writeback can stall
    pipe_stage #(
        .payload_t (mem_wb_bus_t)
    ) u_ws_reg (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (ms_to_ws_valid),
        .in_payload  (ms_to_ws_bus),
        .out_allowin (1'b1),
        .in_allowin  (ws_allowin),
        .out_valid   (ws_valid),
        .out_payload (ws_bus)
    );

    // x0 is hardwired, never written
    assign rf_wen   = ws_valid && ws_bus.reg_wen && (ws_bus.rd != 5'd0);
    assign rf_waddr = ws_bus.rd;
    assign wb_pc    = ws_bus.pc;

    always_comb begin
        case (ws_bus.wreg_sel)
            wsel_load: begin
                rf_wdata = ws_bus.load_data;
            end
            wsel_pc4: begin
                rf_wdata = ws_bus.pc + xlen'(4); // link address for jal/jalr
            end
            default: begin
                rf_wdata = ws_bus.alu_result; // wsel_alu
            end
        endcase
    end

endmodule

/* src/mem_wb_top.sv */
`timescale 1ns/100ps

module mem_wb_top
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            es_valid,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] store_data,
    input  logic            mem_wen,
    input  logic            mem_ren,
    input  logic [2:0]      func3,
    input  logic [1:0]      wreg_sel,
    input  logic            reg_wen,
    input  logic [4:0]      rd,
    output logic            ms_allowin,
    output logic            rf_wen,
    output logic [4:0]      rf_waddr,
    output logic [xlen-1:0] rf_wdata,
    output logic [xlen-1:0] wb_pc
);

    logic        ms_to_ws_valid;
    logic        ws_allowin;
    mem_wb_bus_t ms_to_ws_bus;

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst            (rst),
        .es_valid       (es_valid),
        .pc             (pc),
        .alu_result     (alu_result),
        .store_data     (store_data),
        .mem_wen        (mem_wen),
        .mem_ren        (mem_ren),
        .func3          (func3),
        .wreg_sel       (wreg_sel),
        .reg_wen        (reg_wen),
        .rd             (rd),
        .ws_allowin     (ws_allowin),
        .ms_allowin     (ms_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

    wb_stage u_wb_stage (
        .clk            (clk),
        .rst            (rst),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .rf_wen         (rf_wen),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .wb_pc          (wb_pc)
    );

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter real period_ns = 8.0
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0; // released on a falling edge
    end

endmodule

/* verif/mem_wb_assertions.sv */
`timescale 1ns/100ps

module mem_wb_assertions #(
    parameter type payload_t = logic
) (
    input logic     clk,
    input logic     rst,
    input logic     stage_valid,
    input logic     in_allowin,
    input logic     out_valid,
    input logic     out_allowin,
    input payload_t out_payload
);

    int unsigned fail_count = 0;

    assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after reset");
        end

    // a blocked item must keep its payload
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_allowin |=> $stable(out_payload))
        else begin
            fail_count++;
            $error("payload changed while held by a low out_allowin");
        end

    assert property (@(posedge clk) disable iff (rst) !stage_valid |-> in_allowin)
        else begin
            fail_count++;
            $error("empty stage refused an item");
        end

endmodule

bind pipe_stage mem_wb_assertions #(
    .payload_t (payload_t)
) u_handshake_sva (
    .clk         (clk),
    .rst         (rst),
    .stage_valid (valid_q),
    .in_allowin  (in_allowin),
    .out_valid   (out_valid),
    .out_allowin (out_allowin),
    .out_payload (out_payload)
);

/* verif/mem_wb_tb.sv */
`timescale 1ns/100ps

module mem_wb_tb
    import mem_pkg::*;
();

    localparam logic [1:0] k_alu   = 2'd0;
    localparam logic [1:0] k_store = 2'd1;
    localparam logic [1:0] k_load  = 2'd2;

    // one row is a sweep of count items at base + j*stride
    typedef struct packed {
        logic [1:0]      kind;
        logic [2:0]      func3;
        logic [xlen-1:0] base;
        logic [7:0]      stride;
        logic [7:0]      count;
        logic [1:0]      wreg_sel;
        logic            reg_wen;
        logic [4:0]      rd;
        logic [3:0]      gap;   // idle cycles after each item
    } step_t;

    typedef struct packed {
        logic [31:0]     due;
        logic            wen;
        logic [4:0]      waddr;
        logic [xlen-1:0] wdata;
        logic [xlen-1:0] pc;
    } result_t;

    localparam int n_steps = 23;
    localparam step_t steps [n_steps] = '{
        '{k_store, func3_ld,  64'h000, 8'd8, 8'd8,  wsel_alu,  1'b0, 5'd0,  4'd0}, // fill 0x00..0x3f
        '{k_load,  func3_lb,  64'h000, 8'd1, 8'd16, wsel_load, 1'b1, 5'd5,  4'd0},
        '{k_load,  func3_lbu, 64'h008, 8'd1, 8'd8,  wsel_load, 1'b1, 5'd6,  4'd0},
        '{k_load,  func3_lh,  64'h000, 8'd2, 8'd8,  wsel_load, 1'b1, 5'd7,  4'd1},
        '{k_load,  func3_lhu, 64'h010, 8'd2, 8'd4,  wsel_load, 1'b1, 5'd8,  4'd0},
        '{k_load,  func3_lw,  64'h018, 8'd4, 8'd4,  wsel_load, 1'b1, 5'd9,  4'd0},
        '{k_load,  func3_lwu, 64'h000, 8'd4, 8'd4,  wsel_load, 1'b1, 5'd10, 4'd0},
        '{k_load,  func3_ld,  64'h020, 8'd8, 8'd4,  wsel_load, 1'b1, 5'd11, 4'd2},
        '{k_store, func3_lb,  64'h040, 8'd1, 8'd8,  wsel_alu,  1'b1, 5'd12, 4'd0}, // every lane
        '{k_store, func3_lh,  64'h048, 8'd2, 8'd4,  wsel_alu,  1'b0, 5'd3,  4'd1},
        '{k_store, func3_lw,  64'h050, 8'd4, 8'd2,  wsel_alu,  1'b1, 5'd0,  4'd0},
        '{k_load,  func3_ld,  64'h054, 8'd0, 8'd1,  wsel_load, 1'b1, 5'd13, 4'd0}, // right behind
        '{k_load,  func3_ld,  64'h040, 8'd8, 8'd2,  wsel_load, 1'b1, 5'd14, 4'd0},
        '{k_load,  func3_lh,  64'h021, 8'd1, 8'd8,  wsel_load, 1'b1, 5'd15, 4'd0}, // misaligned
        '{k_store, func3_lw,  64'h1033, 8'd0, 8'd1, wsel_alu,  1'b0, 5'd0,  4'd0}, // wraps to 0x30
        '{k_load,  func3_lwu, 64'h030, 8'd0, 8'd1,  wsel_load, 1'b1, 5'd16, 4'd0},
        '{k_load,  func3_ld,  64'hffff_ffff_ffff_f030, 8'd0, 8'd1, wsel_load, 1'b1, 5'd17, 4'd1},
        '{k_load,  func3_lb,  64'h000, 8'd1, 8'd2,  wsel_alu,  1'b1, 5'd18, 4'd0},
        '{k_alu,   func3_ld,  64'h000, 8'd0, 8'd4,  wsel_alu,  1'b1, 5'd19, 4'd0},
        '{k_alu,   func3_ld,  64'h000, 8'd0, 8'd3,  wsel_pc4,  1'b1, 5'd1,  4'd2},
        '{k_alu,   func3_ld,  64'h000, 8'd0, 8'd2,  wsel_alu,  1'b0, 5'd20, 4'd1},
        '{k_alu,   func3_ld,  64'h000, 8'd0, 8'd2,  wsel_alu,  1'b1, 5'd0,  4'd0},
        '{k_alu,   func3_ld,  64'h000, 8'd0, 8'd2,  wsel_load, 1'b1, 5'd21, 4'd0}
    };

    logic            clk;
    logic            rst;
    logic            es_valid = 1'b0;
    logic [xlen-1:0] pc = '0, alu_result = '0, store_data = '0;
    logic            mem_wen = 1'b0, mem_ren = 1'b0, reg_wen = 1'b0;
    logic [2:0]      func3 = '0;
    logic [1:0]      wreg_sel = '0;
    logic [4:0]      rd = '0;
    logic            ms_allowin, rf_wen;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata, wb_pc;

    logic [7:0]      ref_mem [ram_bytes]; // byte-wide model of the data RAM
    result_t         expect_q [$];
    logic [xlen-1:0] next_pc = 64'h0000_0000_8000_0ff8;
    int              seed = 212;
    int              cycle = 0;
    int              limit = 0;

    tb_clock #(.period_ns(8.0)) u_clock (.clk(clk), .rst(rst));

    mem_wb_top DUT (.*);

    task automatic check_value(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal;
        end
    endtask

    task automatic send_item(input step_t s, input int j);
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic [xlen-1:0] loaded;
        int              nbytes;
        int              idx;
        result_t         r;
        addr        = s.base + s.stride * j;
        data[63:32] = $random(seed);
        data[31:0]  = $random(seed);
        if (s.kind == k_alu) begin
            addr[63:32] = $random(seed);
            addr[31:0]  = $random(seed);
        end
        nbytes = 1 << s.func3[1:0];
        idx    = int'(addr % ram_bytes) & ~(nbytes - 1); // rounded down, wrapped
        loaded = '0;
        for (int b = 0; b < nbytes; b++) begin
            if (s.kind == k_store) begin
                ref_mem[idx + b] = data[8*b +: 8];
            end
            loaded[8*b +: 8] = ref_mem[idx + b];
        end
        if (s.kind != k_load) begin
            loaded = '0; // load data is zero for non-loads
        end else if (!s.func3[2]) begin
            for (int i = 8 * nbytes; i < xlen; i++) begin
                loaded[i] = loaded[8*nbytes - 1];
            end
        end
        es_valid   = 1'b1;
        pc         = next_pc;
        alu_result = addr;
        store_data = data;
        mem_wen    = (s.kind == k_store);
        mem_ren    = (s.kind == k_load);
        func3      = s.func3;
        wreg_sel   = s.wreg_sel;
        reg_wen    = s.reg_wen;
        rd         = s.rd;
        r.due      = cycle + 2; // two edges to writeback
        r.wen      = s.reg_wen && (s.rd != 5'd0);
        r.waddr    = s.rd;
        r.pc       = next_pc;
        case (s.wreg_sel)
            wsel_load: r.wdata = loaded;
            wsel_pc4:  r.wdata = next_pc + 4;
            default:   r.wdata = addr;
        endcase
        expect_q.push_back(r);
        next_pc = next_pc + 4;
    endtask

    // outputs settle at the rising edge, so sample mid-cycle
    always @(negedge clk) begin : check_writeback
        result_t r;
        if (cycle >= 2) begin
            check_value(ms_allowin, 1'b1, "ms_allowin");
            if (expect_q.size() > 0 && expect_q[0].due == cycle) begin
                r = expect_q.pop_front();
                check_value(rf_wen, r.wen, "rf_wen");
                check_value(wb_pc, r.pc, "wb_pc");
                if (r.wen) begin
                    check_value(rf_waddr, r.waddr, "rf_waddr");
                    check_value(rf_wdata, r.wdata, "rf_wdata");
                end
            end else begin
                check_value(rf_wen, 1'b0, "rf_wen with no item due");
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", limit);
            $display("Checks failed");
            $fatal;
        end
    end

    initial begin
        int          items;
        int          gaps;
        int unsigned sva_fails;
        items = 0;
        gaps  = 0;
        for (int i = 0; i < n_steps; i++) begin
            items += steps[i].count;
            gaps  += steps[i].count * steps[i].gap;
        end
        limit = 2 * items + gaps + 20;
        @(negedge rst);
        for (int i = 0; i < n_steps; i++) begin
            for (int j = 0; j < steps[i].count; j++) begin
                @(negedge clk);
                while (!ms_allowin) begin
                    es_valid = 1'b0;
                    @(negedge clk);
                end
                send_item(steps[i], j);
                repeat (steps[i].gap) begin
                    @(negedge clk);
                    es_valid = 1'b0;
                end
            end
        end
        @(negedge clk);
        es_valid = 1'b0;
        repeat (3) @(negedge clk); // last item retires on the first of these
        sva_fails = DUT.u_mem_stage.u_ms_reg.u_handshake_sva.fail_count
                  + DUT.u_wb_stage.u_ws_reg.u_handshake_sva.fail_count;
        if (expect_q.size() != 0 || sva_fails != 0) begin
            $display("Run incomplete: %0d items never retired, %0d handshake assertion failures",
                     expect_q.size(), sva_fails);
            $display("Checks failed");
            $fatal;
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* project.f */
src/mem_pkg.sv
src/pipe_stage.sv
src/store_format.sv
src/data_ram.sv
src/load_extend.sv
src/mem_stage.sv
src/wb_stage.sv
src/mem_wb_top.sv
verif/tb_clock.sv
verif/mem_wb_assertions.sv
verif/mem_wb_tb.sv
